//--- csu_config.svh
// Build-time sizes for the CSU scheduler and execute pipeline.
// Include this before using any CSU_* macro.

`ifndef CSU_CONFIG_SVH
`define CSU_CONFIG_SVH

// Scheduler
`define CSU_QUEUE_DEPTH 4

// Tags
`define CSU_RNID_W      4   // 16 physical registers
`define CSU_CMT_ID_W    5

// Datapath and CSR space
`define CSU_CSR_NUM     8
`define CSU_XLEN        32

`endif

//--- csu_pkg.sv
// Shared types for the CSU scheduler, the execute stage and the testbench.
// Import with csu_pkg::* in the module header.

`include "csu_config.svh"

package csu_pkg;

  typedef logic [`CSU_RNID_W-1:0]           rnid_t;
  typedef logic [`CSU_CMT_ID_W-1:0]         cmt_id_t;  // ROB id, compared with head
  typedef logic [$clog2(`CSU_CSR_NUM)-1:0]  csr_addr_t;
  typedef logic [`CSU_XLEN-1:0]             xlen_t;

  // --------------------------------------------------
  // CSR operation and instruction payload
  // --------------------------------------------------
  typedef enum logic [1:0] {
    CSR_RW = 2'd0,   // Write rs1
    CSR_RS = 2'd1,   // Set bits of rs1
    CSR_RC = 2'd2    // Clear bits of rs1
  } csr_op_t;

  typedef struct packed {
    cmt_id_t   cmt_id;
    csr_op_t   op;
    csr_addr_t csr_addr;
    rnid_t     rs1_rnid;
    logic      rs1_ready;
    rnid_t     rd_rnid;
    logic      serial;     // Hold until ROB head
  } disp_t;

  typedef struct packed {
    logic  valid;
    disp_t inst;
  } issue_t;

  // --------------------------------------------------
  // Scheduler entry states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    S_INIT   = 2'd0,
    S_WAIT   = 2'd1,
    S_ISSUED = 2'd2,
    S_CLEAR  = 2'd3
  } sched_state_t;

endpackage

//--- csu_wr_if.sv
// Physical register write bus. The execute stage drives it and every
// scheduler entry snoops it as the wakeup broadcast.

`timescale 1ns/1ps

interface csu_wr_if
  import csu_pkg::*;
();

  logic  valid;     // Single-cycle strobe
  rnid_t rnid;
  xlen_t data;
  logic  src_ext;   // Write came from the external port

  modport producer (
    output valid, rnid, data, src_ext
  );

  modport consumer (
    input valid, rnid, data, src_ext
  );

endinterface

//--- csu_issue_entry.sv
// One CSU scheduler entry. Holds a dispatched CSR instruction, tracks rs1
// readiness from the wakeup bus and offers itself to the picker.

`timescale 1ns/1ps
`include "csu_config.svh"

module csu_issue_entry
  import csu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_put,
  input  disp_t             i_put_data,
  input  logic              i_flush,
  input  cmt_id_t           i_rob_head_cmt_id,

  csu_wr_if.consumer        wr_if,

  input  logic              i_picked,
  output logic              o_valid,
  output logic              o_ready,
  output issue_t            o_entry
);

  sched_state_t r_state;
  sched_state_t w_state_next;
  disp_t        r_inst;
  disp_t        w_inst_next;
  rnid_t        w_rs1_rnid;
  logic         w_rs1_hit;
  logic         w_serial_ok;

  // At put time the incoming tag is compared, so a same-cycle write is not lost
  assign w_rs1_rnid = i_put ? i_put_data.rs1_rnid : r_inst.rs1_rnid;
  assign w_rs1_hit  = wr_if.valid & (wr_if.rnid == w_rs1_rnid);

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    w_state_next          = r_state;
    w_inst_next           = r_inst;
    w_inst_next.rs1_ready = r_inst.rs1_ready | w_rs1_hit;

    case (r_state)
      S_INIT: begin
        if (i_put) begin
          w_inst_next           = i_put_data;
          w_inst_next.rs1_ready = i_put_data.rs1_ready | w_rs1_hit;
          // A put on the flush edge is dead on arrival
          w_state_next          = i_flush ? S_CLEAR : S_WAIT;
        end
      end
      S_WAIT: begin
        if (i_flush) begin
          w_state_next = S_CLEAR;
        end else if (i_picked) begin
          w_state_next = S_ISSUED;
        end
      end
      S_ISSUED: begin
        w_state_next = S_CLEAR;
      end
      default: begin
        w_state_next = S_INIT;            // S_CLEAR frees the slot
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= S_INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    r_inst <= w_inst_next;
  end

  // Serialized ops run only at the ROB head
  assign w_serial_ok = !r_inst.serial | (i_rob_head_cmt_id == r_inst.cmt_id);

  assign o_valid = (r_state != S_INIT);
  assign o_ready = (r_state == S_WAIT) & r_inst.rs1_ready & w_serial_ok;
  assign o_entry = '{valid: o_valid, inst: r_inst};

  // --------------------------------------------------
  // Checks against the queue
  // --------------------------------------------------
  a_put_only_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_put |-> (r_state == S_INIT))
    else $error("entry: put into an occupied slot");

  a_pick_only_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_ready)
    else $error("entry: picked while not ready");

endmodule

//--- csu_issue_queue.sv
// CSU issue queue. Allocates the lowest free entry on dispatch, picks the
// oldest ready entry through an age matrix and registers it for execute.

`timescale 1ns/1ps
`include "csu_config.svh"

module csu_issue_queue
  import csu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_disp_valid,
  input  disp_t             i_disp,
  input  logic              i_flush,
  input  cmt_id_t           i_rob_head_cmt_id,

  csu_wr_if.consumer        wr_if,

  output logic              o_full,
  output logic              o_iss_valid,
  output issue_t            o_iss
);

  localparam int DEPTH = `CSU_QUEUE_DEPTH;

  logic [DEPTH-1:0] w_valid;
  logic [DEPTH-1:0] w_ready;
  logic [DEPTH-1:0] w_put;
  logic [DEPTH-1:0] w_grant;
  logic [DEPTH-1:0] w_picked;
  issue_t           w_entry [DEPTH];
  logic [DEPTH-1:0] r_older [DEPTH];   // [i][j] set when entry i is older than j
  issue_t           w_pick_entry;
  logic             w_pick_valid;
  logic             r_iss_valid;
  issue_t           r_iss;

  for (genvar g = 0; g < DEPTH; g++) begin : g_entry
    csu_issue_entry u_entry (
      .i_clk             (i_clk),
      .i_reset_n         (i_reset_n),
      .i_put             (w_put[g]),
      .i_put_data        (i_disp),
      .i_flush           (i_flush),
      .i_rob_head_cmt_id (i_rob_head_cmt_id),
      .wr_if             (wr_if),
      .i_picked          (w_picked[g]),
      .o_valid           (w_valid[g]),
      .o_ready           (w_ready[g]),
      .o_entry           (w_entry[g])
    );
  end

  // --------------------------------------------------
  // Allocation
  // --------------------------------------------------
  always_comb begin
    w_put = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!w_valid[i]) begin
        w_put    = '0;
        w_put[i] = i_disp_valid;        // Lowest free index wins
      end
    end
  end

  assign o_full = &w_valid;

  // New entry is younger than everything already held
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        r_older[i] <= '0;
      end
    end else begin
      for (int k = 0; k < DEPTH; k++) begin
        if (w_put[k]) begin
          for (int i = 0; i < DEPTH; i++) begin
            r_older[k][i] <= 1'b0;
            if (i != k) begin
              r_older[i][k] <= 1'b1;
            end
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Oldest-ready pick
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      w_grant[i] = w_ready[i];
      for (int j = 0; j < DEPTH; j++) begin
        if (j != i && w_ready[j] && r_older[j][i]) begin
          w_grant[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    w_pick_entry = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (w_grant[i]) begin
        w_pick_entry = w_entry[i];
      end
    end
  end

  assign w_pick_valid = |w_grant;
  assign w_picked     = w_grant & {DEPTH{~i_flush}};   // Flush wins over pick

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_iss_valid <= 1'b0;
    end else begin
      r_iss_valid <= w_pick_valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_pick_valid) begin
      r_iss <= w_pick_entry;
    end
  end

  assign o_iss_valid = r_iss_valid;
  assign o_iss       = r_iss;

  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> !o_full)
    else $error("queue: dispatch while full");

endmodule

//--- csu_execute.sv
// CSU execute stage. Reads rs1 and the addressed CSR for an issued op,
// updates the CSR and writes the old value back to rd with a wakeup.

`timescale 1ns/1ps
`include "csu_config.svh"

module csu_execute
  import csu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_iss_valid,
  input  issue_t            i_iss,

  input  logic              i_ext_wr_valid,
  input  rnid_t             i_ext_wr_rnid,
  input  xlen_t             i_ext_wr_data,

  csu_wr_if.producer        wr_if,

  output logic              o_done_valid,
  output cmt_id_t           o_done_cmt_id,
  output xlen_t             o_done_data
);

  localparam int PRF_NUM = 1 << `CSU_RNID_W;

  xlen_t   r_prf [PRF_NUM];
  xlen_t   r_csr [`CSU_CSR_NUM];
  logic    w_op_valid;
  xlen_t   w_rs1_data;
  xlen_t   w_csr_old;
  xlen_t   w_csr_new;
  logic    r_wb_valid;
  rnid_t   r_wb_rnid;
  xlen_t   r_wb_data;
  cmt_id_t r_wb_cmt_id;

  assign w_op_valid = i_iss_valid & i_iss.valid;
  assign w_rs1_data = r_prf[i_iss.inst.rs1_rnid];
  assign w_csr_old  = r_csr[i_iss.inst.csr_addr];

  always_comb begin
    case (i_iss.inst.op)
      CSR_RS:  w_csr_new = w_csr_old | w_rs1_data;
      CSR_RC:  w_csr_new = w_csr_old & ~w_rs1_data;
      default: w_csr_new = w_rs1_data;             // CSR_RW
    endcase
  end

  // --------------------------------------------------
  // CSR update and writeback register
  // --------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `CSU_CSR_NUM; i++) begin
        r_csr[i] <= '0;
      end
      r_wb_valid <= 1'b0;
    end else begin
      if (w_op_valid) begin
        r_csr[i_iss.inst.csr_addr] <= w_csr_new;
      end
      r_wb_valid <= w_op_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_wb_rnid   <= i_iss.inst.rd_rnid;
    r_wb_data   <= w_csr_old;                       // Old value goes to rd
    r_wb_cmt_id <= i_iss.inst.cmt_id;
  end

  // External producer has priority on the shared write bus
  assign wr_if.valid   = i_ext_wr_valid | r_wb_valid;
  assign wr_if.src_ext = i_ext_wr_valid;
  assign wr_if.rnid    = i_ext_wr_valid ? i_ext_wr_rnid : r_wb_rnid;
  assign wr_if.data    = i_ext_wr_valid ? i_ext_wr_data : r_wb_data;

  // Register file follows the merged bus
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < PRF_NUM; i++) begin
        r_prf[i] <= '0;
      end
    end else if (wr_if.valid) begin
      r_prf[wr_if.rnid] <= wr_if.data;
    end
  end

  assign o_done_valid  = r_wb_valid;
  assign o_done_cmt_id = r_wb_cmt_id;
  assign o_done_data   = r_wb_data;

  a_no_wr_collision: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    wr_if.src_ext |-> !r_wb_valid)
    else $error("execute: external write collided with writeback");

endmodule

//--- csu_top.sv
// CSU scheduler and execute pipeline top. Flat ports for dispatch, flush,
// ROB head, external register writes and completion.

`timescale 1ns/1ps
`include "csu_config.svh"

module csu_top
  import csu_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_disp_valid,
  input  cmt_id_t    i_disp_cmt_id,
  input  csr_op_t    i_disp_op,
  input  csr_addr_t  i_disp_csr_addr,
  input  rnid_t      i_disp_rs1_rnid,
  input  logic       i_disp_rs1_ready,
  input  rnid_t      i_disp_rd_rnid,
  input  logic       i_disp_serial,
  input  logic       i_flush,
  input  cmt_id_t    i_rob_head_cmt_id,
  input  logic       i_ext_wr_valid,
  input  rnid_t      i_ext_wr_rnid,
  input  xlen_t      i_ext_wr_data,
  output logic       o_queue_full,
  output logic       o_done_valid,
  output cmt_id_t    o_done_cmt_id,
  output xlen_t      o_done_data
);

  disp_t  w_disp;
  logic   w_iss_valid;
  issue_t w_iss;

  csu_wr_if wr_if ();

  assign w_disp = '{cmt_id:    i_disp_cmt_id,
                    op:        i_disp_op,
                    csr_addr:  i_disp_csr_addr,
                    rs1_rnid:  i_disp_rs1_rnid,
                    rs1_ready: i_disp_rs1_ready,
                    rd_rnid:   i_disp_rd_rnid,
                    serial:    i_disp_serial};

  csu_issue_queue u_queue (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_disp_valid (i_disp_valid), .i_disp (w_disp), .i_flush (i_flush),
    .i_rob_head_cmt_id (i_rob_head_cmt_id), .wr_if (wr_if.consumer),
    .o_full (o_queue_full), .o_iss_valid (w_iss_valid), .o_iss (w_iss)
  );

  csu_execute u_execute (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_iss_valid (w_iss_valid), .i_iss (w_iss),
    .i_ext_wr_valid (i_ext_wr_valid), .i_ext_wr_rnid (i_ext_wr_rnid),
    .i_ext_wr_data (i_ext_wr_data), .wr_if (wr_if.producer),
    .o_done_valid (o_done_valid), .o_done_cmt_id (o_done_cmt_id),
    .o_done_data (o_done_data)
  );

endmodule

//--- tb_csu.sv
// Testbench for the CSU scheduler and execute pipeline.
// A reference model tracks CSRs and physical registers in completion order;
// concurrent assertions compare every completion against it.

`timescale 1ns/1ps
`include "csu_config.svh"

module tb_csu
  import csu_pkg::*;
();

  localparam int WAIT_LIMIT = 100;

  logic      i_clk = 1'b0;
  logic      i_reset_n;
  logic      i_disp_valid;
  cmt_id_t   i_disp_cmt_id;
  csr_op_t   i_disp_op;
  csr_addr_t i_disp_csr_addr;
  rnid_t     i_disp_rs1_rnid;
  logic      i_disp_rs1_ready;
  rnid_t     i_disp_rd_rnid;
  logic      i_disp_serial;
  logic      i_flush;
  cmt_id_t   i_rob_head_cmt_id;
  logic      i_ext_wr_valid;
  rnid_t     i_ext_wr_rnid;
  xlen_t     i_ext_wr_data;
  logic      o_queue_full;
  logic      o_done_valid;
  cmt_id_t   o_done_cmt_id;
  xlen_t     o_done_data;

  integer    seed = 32'h735744ee;
  int        n_value_err = 0;
  int        n_proto_err = 0;
  int        n_timeout = 0;
  cmt_id_t   r_next_id = '0;
  logic      lat_mode;       // Single dispatch under latency check
  logic      hold_active;    // hold_id must not complete
  cmt_id_t   hold_id;
  logic      chk_full;

  csu_top DUT (.*);

  always #4 i_clk = ~i_clk;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  xlen_t     m_csr [`CSU_CSR_NUM];
  xlen_t     m_prf [1 << `CSU_RNID_W];
  csr_op_t   m_op [1 << `CSU_CMT_ID_W];
  csr_addr_t m_addr [1 << `CSU_CMT_ID_W];
  rnid_t     m_rs1 [1 << `CSU_CMT_ID_W];
  rnid_t     m_rd [1 << `CSU_CMT_ID_W];
  logic [(1 << `CSU_CMT_ID_W)-1:0] m_pending;
  xlen_t     w_exp_old;
  logic      lat_disp;

  function automatic xlen_t csr_apply(input csr_op_t op, input xlen_t old_val,
                                      input xlen_t src);
    if (op == CSR_RS) begin
      return old_val | src;          // Set
    end else if (op == CSR_RC) begin
      return old_val & ~src;         // Clear
    end
    return src;
  endfunction

  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      m_pending <= '0;
      for (int i = 0; i < `CSU_CSR_NUM; i++) begin
        m_csr[i] <= '0;
      end
      for (int i = 0; i < (1 << `CSU_RNID_W); i++) begin
        m_prf[i] <= '0;
      end
      for (int i = 0; i < (1 << `CSU_CMT_ID_W); i++) begin
        m_addr[i] <= '0;
      end
    end else begin
      if (i_disp_valid) begin
        m_pending[i_disp_cmt_id] <= 1'b1;
        m_op[i_disp_cmt_id]      <= i_disp_op;
        m_addr[i_disp_cmt_id]    <= i_disp_csr_addr;
        m_rs1[i_disp_cmt_id]     <= i_disp_rs1_rnid;
        m_rd[i_disp_cmt_id]      <= i_disp_rd_rnid;
      end
      // Flush is only issued while every outstanding op is still waiting
      if (i_flush) begin
        m_pending <= '0;
      end
      if (o_done_valid) begin
        m_pending[o_done_cmt_id] <= 1'b0;
        m_csr[m_addr[o_done_cmt_id]] <= csr_apply(m_op[o_done_cmt_id],
          m_csr[m_addr[o_done_cmt_id]], m_prf[m_rs1[o_done_cmt_id]]);
        m_prf[m_rd[o_done_cmt_id]] <= m_csr[m_addr[o_done_cmt_id]];
      end
      if (i_ext_wr_valid) begin
        m_prf[i_ext_wr_rnid] <= i_ext_wr_data;
      end
    end
  end

  assign w_exp_old = m_csr[m_addr[o_done_cmt_id]];   // Old CSR value for this completion
  assign lat_disp  = lat_mode & i_disp_valid;

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_done_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid |-> m_pending[o_done_cmt_id])
    else begin
      n_proto_err++;
      $display("Unexpected completion of cmt_id %0d", $sampled(o_done_cmt_id));
    end

  a_done_data: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid |-> (o_done_data == w_exp_old))
    else begin
      n_value_err++;
      $display("FAILED o_done_data (cmt_id %h): got %h expected %h",
               $sampled(o_done_cmt_id), $sampled(o_done_data), $sampled(w_exp_old));
    end

  a_lat_early: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    ($past(lat_disp) || $past(lat_disp, 2)) |-> !o_done_valid)
    else begin
      n_proto_err++;
      $display("Completion arrived earlier than 3 cycles after dispatch");
    end

  a_lat_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $past(lat_disp, 3) |-> (o_done_valid && o_done_cmt_id == $past(i_disp_cmt_id, 3)))
    else begin
      n_proto_err++;
      $display("No completion of the dispatched op 3 cycles after dispatch");
    end

  a_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    hold_active |-> !(o_done_valid && o_done_cmt_id == hold_id))
    else begin
      n_proto_err++;
      $display("cmt_id %0d completed before its operand or ROB head allowed it", hold_id);
    end

  a_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    chk_full |-> o_queue_full)
    else begin
      n_value_err++;
      $display("FAILED o_queue_full: got %h expected %h", $sampled(o_queue_full), 1'b1);
    end

  // --------------------------------------------------
  // Stimulus helpers, all entered on a falling edge
  // --------------------------------------------------
  task automatic send_op(input csr_op_t op, input csr_addr_t addr, input rnid_t rs1,
                         input logic rdy, input rnid_t rd, input logic serial,
                         output cmt_id_t id);
    int n;
    n  = 0;
    id = r_next_id;
    while (o_queue_full && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (o_queue_full) begin
      n_timeout++;
      $display("Timeout: queue stayed full, dispatch of cmt_id %0d dropped", id);
    end else begin
      i_disp_valid     = 1'b1;
      i_disp_cmt_id    = id;
      i_disp_op        = op;
      i_disp_csr_addr  = addr;
      i_disp_rs1_rnid  = rs1;
      i_disp_rs1_ready = rdy;
      i_disp_rd_rnid   = rd;
      i_disp_serial    = serial;
      r_next_id        = cmt_id_t'(r_next_id + 1);
      @(negedge i_clk);
      i_disp_valid     = 1'b0;
    end
  endtask

  task automatic ext_write(input rnid_t rnid, input xlen_t data);
    i_ext_wr_valid = 1'b1;
    i_ext_wr_rnid  = rnid;
    i_ext_wr_data  = data;
    @(negedge i_clk);
    i_ext_wr_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (m_pending != '0 && n < WAIT_LIMIT) begin
      @(negedge i_clk);
      n++;
    end
    if (m_pending != '0) begin
      n_timeout++;
      $display("Timeout: operations %h never completed", m_pending);
    end
  endtask

  task automatic wait_not_full();
    int n;
    n = 0;
    while (o_queue_full && n < 10) begin
      @(negedge i_clk);
      n++;
    end
    if (o_queue_full) begin
      n_timeout++;
      $display("Timeout: queue still full after flush");
    end
  endtask

  // Reads a CSR through the model check, rs1 = p0 stays zero
  task automatic peek_csr(input csr_addr_t addr);
    cmt_id_t id;
    send_op(CSR_RS, addr, rnid_t'(0), 1'b1, rnid_t'(8), 1'b0, id);
    wait_idle();
  endtask

  function automatic csr_op_t rand_op();
    int r;
    r = $unsigned($random(seed)) % 3;
    return (r == 0) ? CSR_RW : (r == 1) ? CSR_RS : CSR_RC;
  endfunction

  function automatic rnid_t rand_src();
    return rnid_t'(1 + $unsigned($random(seed)) % 7);    // p1..p7
  endfunction

  function automatic rnid_t rand_dst();
    return rnid_t'(8 + $unsigned($random(seed)) % 7);    // p8..p14, p15 is for chaining
  endfunction

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    cmt_id_t id;
    i_reset_n = 1'b0;
    {i_disp_valid, i_disp_rs1_ready, i_disp_serial, i_flush, i_ext_wr_valid} = '0;
    i_disp_cmt_id = '0;
    i_disp_op = CSR_RW;
    i_disp_csr_addr = '0;
    {i_disp_rs1_rnid, i_disp_rd_rnid, i_ext_wr_rnid} = '0;
    i_rob_head_cmt_id = '0;
    i_ext_wr_data = '0;
    {lat_mode, hold_active, chk_full} = '0;
    hold_id = '0;
    repeat (2) @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    for (int r = 1; r < 8; r++) begin
      ext_write(rnid_t'(r), $random(seed));
    end

    // Lone ready read-write, fixed latency, then read back
    lat_mode = 1'b1;
    send_op(CSR_RW, csr_addr_t'(2), rnid_t'(1), 1'b1, rnid_t'(9), 1'b0, id);
    lat_mode = 1'b0;
    wait_idle();
    peek_csr(csr_addr_t'(2));

    // Random set and clear traffic
    for (int k = 0; k < 12; k++) begin
      send_op(rand_op(), csr_addr_t'($random(seed)), rand_src(), 1'b1, rand_dst(),
              1'b0, id);
      if ($random(seed) & 1) begin
        @(negedge i_clk);
      end
    end
    wait_idle();

    // Operand not ready until the external write
    send_op(CSR_RS, csr_addr_t'(3), rnid_t'(6), 1'b0, rnid_t'(10), 1'b0, id);
    hold_id     = id;
    hold_active = 1'b1;
    repeat (8) @(negedge i_clk);
    hold_active = 1'b0;
    ext_write(rnid_t'(6), $random(seed));
    wait_idle();
    peek_csr(csr_addr_t'(3));

    // Serialized op waits for the ROB head
    i_rob_head_cmt_id = cmt_id_t'(r_next_id + 3);
    send_op(CSR_RC, csr_addr_t'(4), rnid_t'(2), 1'b1, rnid_t'(11), 1'b1, id);
    hold_id     = id;
    hold_active = 1'b1;
    repeat (8) @(negedge i_clk);
    hold_active       = 1'b0;
    i_rob_head_cmt_id = id;
    wait_idle();
    peek_csr(csr_addr_t'(4));

    // Four waiting entries fill the queue, flush removes them
    for (int k = 0; k < 4; k++) begin
      send_op(CSR_RW, csr_addr_t'(k), rnid_t'(5), 1'b0, rnid_t'(8 + k), 1'b0, id);
    end
    chk_full = 1'b1;
    i_flush  = 1'b1;
    @(negedge i_clk);
    chk_full = 1'b0;
    i_flush  = 1'b0;
    wait_not_full();
    ext_write(rnid_t'(5), $random(seed));   // Would wake them if still alive
    repeat (10) @(negedge i_clk);

    // Back-to-back stream, op 4 chained on rd of op 3
    for (int k = 0; k < 8; k++) begin
      if (k == 3) begin
        send_op(rand_op(), csr_addr_t'($random(seed)), rand_src(), 1'b1, rnid_t'(15),
                1'b0, id);
      end else if (k == 4) begin
        send_op(rand_op(), csr_addr_t'($random(seed)), rnid_t'(15), 1'b0, rand_dst(),
                1'b0, id);
      end else begin
        send_op(rand_op(), csr_addr_t'($random(seed)), rand_src(), 1'b1, rand_dst(),
                1'b0, id);
      end
    end
    wait_idle();
    for (int a = 0; a < `CSU_CSR_NUM; a++) begin
      peek_csr(csr_addr_t'(a));
    end
    repeat (4) @(negedge i_clk);

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             n_value_err, n_proto_err, n_timeout);
    if (n_value_err + n_proto_err + n_timeout == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
csu_pkg.sv
csu_wr_if.sv
csu_issue_entry.sv
csu_issue_queue.sv
csu_execute.sv
csu_top.sv
tb_csu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_csu
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
